/* hw/spi_reg_pkg.sv */
// spi register bank package: command codes, register addresses, version values, reset values
`default_nettype none

package spi_reg_pkg;

	// --------------------------------------------------
	// spi command byte
	// --------------------------------------------------
	localparam logic [7:0] SPI_CMD_RD = 8'h80;
	localparam logic [7:0] SPI_CMD_WR = 8'h02;

	// --------------------------------------------------
	// fixed register addresses, low 9 bits decoded
	// --------------------------------------------------
	localparam logic [8:0] ADDR_VENDOR_ID  = 9'h000;
	localparam logic [8:0] ADDR_PRODUCT_ID = 9'h001;
	localparam logic [8:0] ADDR_FPGA_VER_H = 9'h002;
	localparam logic [8:0] ADDR_FPGA_VER_L = 9'h003;
	localparam logic [8:0] ADDR_TEST_VER   = 9'h004;

	// version words returned by the fixed list
	localparam logic [15:0] VENDOR_ID      = 16'h4448;
	localparam logic [15:0] PRODUCT_ID     = 16'h0000;
	localparam logic [15:0] FPGA_VERSION_H = 16'h0102;
	localparam logic [15:0] FPGA_VERSION_L = 16'h0123;
	localparam logic [15:0] TEST_VERSION   = 16'h2000;

	// --------------------------------------------------
	// control register addresses, low 9 bits decoded
	// --------------------------------------------------
	localparam logic [8:0] ADDR_STREAM_EN    = 9'h020;
	localparam logic [8:0] ADDR_EXPOSURE     = 9'h021;
	localparam logic [8:0] ADDR_GAIN         = 9'h022;
	localparam logic [8:0] ADDR_TEST_PATTERN = 9'h023;

	// power-up exposure and gain
	// stream enable and test pattern come up as zero
	localparam logic [15:0] EXPOSURE_RST = 16'h0400;
	localparam logic [7:0]  GAIN_RST     = 8'h10;

endpackage

`default_nettype wire

/* hw/fix_reg_list.sv */
// fixed register list: read-only vendor, product and version words
`default_nettype none

module fix_reg_list #(
	parameter int SPI_ADDR_LENGTH = 16,
	parameter int SHORT_REG_WD    = 16
) (
	// read level and address from the sampler
	input  wire logic                       rd_en,
	input  wire logic [SPI_ADDR_LENGTH-1:0] addr,
	// select flag and read word
	output logic                            fix_sel,
	output logic [SHORT_REG_WD-1:0]         fix_rd_data
);
	import spi_reg_pkg::*;

	// msb is the select flag, the rest is the word
	logic [SHORT_REG_WD:0] rd_word;

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------
	always_comb begin
		rd_word = '0;
		// nothing claimed outside a read
		if (rd_en) begin
			case (addr[8:0])
				// identification
				ADDR_VENDOR_ID: begin
					rd_word = {1'b1, SHORT_REG_WD'(VENDOR_ID)};
				end
				ADDR_PRODUCT_ID: begin
					rd_word = {1'b1, SHORT_REG_WD'(PRODUCT_ID)};
				end
				// fpga version halves
				ADDR_FPGA_VER_H: begin
					rd_word = {1'b1, SHORT_REG_WD'(FPGA_VERSION_H)};
				end
				ADDR_FPGA_VER_L: begin
					rd_word = {1'b1, SHORT_REG_WD'(FPGA_VERSION_L)};
				end
				ADDR_TEST_VER: begin
					rd_word = {1'b1, SHORT_REG_WD'(TEST_VERSION)};
				end
				default: begin
					rd_word = '0;
				end
			endcase
		end
	end

	assign fix_sel     = rd_word[SHORT_REG_WD];
	assign fix_rd_data = rd_word[SHORT_REG_WD-1:0];

endmodule

`default_nettype wire

/* hw/ctrl_reg_list.sv */
// control register list: writable stream, exposure, gain and test pattern registers
`default_nettype none

module ctrl_reg_list #(
	parameter int SPI_ADDR_LENGTH = 16,
	parameter int SHORT_REG_WD    = 16
) (
	input  wire logic                       clk_sample,
	input  wire logic                       rst,
	// access from the sampler
	input  wire logic                       rd_en,
	input  wire logic                       wr_en,
	input  wire logic [SPI_ADDR_LENGTH-1:0] addr,
	input  wire logic [SHORT_REG_WD-1:0]    wr_data,
	// readback
	output logic                            ctrl_sel,
	output logic [SHORT_REG_WD-1:0]         ctrl_rd_data,
	// to the camera fabric
	output logic                            stream_en,
	output logic [15:0]                     exposure,
	output logic [7:0]                      gain,
	output logic [1:0]                      test_pattern
);
	import spi_reg_pkg::*;

	// select flag on top of the zero-extended field
	logic [SHORT_REG_WD:0] rd_word;

	// --------------------------------------------------
	// register writes
	// --------------------------------------------------
	// only the low bits that fit each field are kept
	always_ff @(posedge clk_sample) begin
		if (rst) begin
			stream_en    <= 1'b0;
			exposure     <= EXPOSURE_RST;
			gain         <= GAIN_RST;
			test_pattern <= 2'b00;
		end else if (wr_en) begin
			case (addr[8:0])
				ADDR_STREAM_EN: begin
					stream_en <= wr_data[0];
				end
				ADDR_EXPOSURE: begin
					exposure <= wr_data[15:0];
				end
				ADDR_GAIN: begin
					gain <= wr_data[7:0];
				end
				ADDR_TEST_PATTERN: begin
					test_pattern <= wr_data[1:0];
				end
				// unmapped, dropped
				default: begin
				end
			endcase
		end
	end

	// --------------------------------------------------
	// readback
	// --------------------------------------------------
	always_comb begin
		rd_word = '0;
		if (rd_en) begin
			case (addr[8:0])
				ADDR_STREAM_EN: begin
					rd_word = {1'b1, SHORT_REG_WD'(stream_en)};
				end
				ADDR_EXPOSURE: begin
					rd_word = {1'b1, SHORT_REG_WD'(exposure)};
				end
				ADDR_GAIN: begin
					rd_word = {1'b1, SHORT_REG_WD'(gain)};
				end
				ADDR_TEST_PATTERN: begin
					rd_word = {1'b1, SHORT_REG_WD'(test_pattern)};
				end
				default: begin
					rd_word = '0;
				end
			endcase
		end
	end

	assign ctrl_sel     = rd_word[SHORT_REG_WD];
	assign ctrl_rd_data = rd_word[SHORT_REG_WD-1:0];

	// a write never lands while a read holds the address
	a_wr_no_rd: assert property (@(posedge clk_sample) disable iff (rst)
		wr_en |-> !rd_en);

endmodule

`default_nettype wire

/* hw/spi_sampler.sv */
// spi sampler: pin synchroniser, frame shifter, command decode, read data select, miso shifter
`default_nettype none

module spi_sampler #(
	parameter int SPI_ADDR_LENGTH = 16,
	parameter int SHORT_REG_WD    = 16
) (
	input  wire logic                       clk_sample,
	input  wire logic                       rst,
	// spi pins, asynchronous to clk_sample
	input  wire logic                       spi_sck,
	input  wire logic                       spi_cs_n,
	input  wire logic                       spi_mosi,
	output logic                            spi_miso,
	// register list side
	output logic                            rd_en,
	output logic                            wr_en,
	output logic [SPI_ADDR_LENGTH-1:0]      addr,
	output logic [SHORT_REG_WD-1:0]         wr_data,
	input  wire logic                       fix_sel,
	input  wire logic [SHORT_REG_WD-1:0]    fix_rd_data,
	input  wire logic                       ctrl_sel,
	input  wire logic [SHORT_REG_WD-1:0]    ctrl_rd_data
);
	import spi_reg_pkg::*;

	// frame layout: cmd byte, address, data word
	localparam int CMD_BITS   = 8;
	localparam int RD_BIT     = CMD_BITS + SPI_ADDR_LENGTH;
	localparam int FRAME_BITS = RD_BIT + SHORT_REG_WD;
	localparam int CNT_WD     = $clog2(FRAME_BITS + 1);
	localparam int WORD_WD    = (SPI_ADDR_LENGTH > SHORT_REG_WD) ? SPI_ADDR_LENGTH : SHORT_REG_WD;

	// bit counter values where each field completes
	localparam logic [CNT_WD-1:0] CNT_CMD_END  = CNT_WD'(CMD_BITS - 1);
	localparam logic [CNT_WD-1:0] CNT_ADDR_END = CNT_WD'(RD_BIT - 1);
	localparam logic [CNT_WD-1:0] CNT_DATA_END = CNT_WD'(FRAME_BITS - 1);
	// msb held over the first falling edge after the address
	localparam logic [CNT_WD-1:0] CNT_MISO_HOLD = CNT_WD'(RD_BIT);
	localparam logic [CNT_WD-1:0] CNT_FULL      = CNT_WD'(FRAME_BITS);

	logic [2:0]              sck_sync;
	logic [2:0]              cs_sync;
	logic [1:0]              mosi_sync;
	logic                    sck_rise;
	logic                    sck_fall;
	logic                    cs_rise;
	logic                    cs_active;
	logic                    shift_en;
	logic [CNT_WD-1:0]       bit_cnt;
	logic [WORD_WD-2:0]      shift_in;
	logic [WORD_WD-1:0]      shift_nxt;
	logic [7:0]              cmd;
	logic                    rd_en_d;
	logic                    rd_load;
	logic [SHORT_REG_WD-1:0] rd_sel_data;
	logic [SHORT_REG_WD-1:0] miso_sh;

	// --------------------------------------------------
	// pin synchroniser and edge detect
	// --------------------------------------------------
	// two flops per pin, third stage only for edges
	always_ff @(posedge clk_sample) begin
		if (rst) begin
			sck_sync <= 3'b000;
			cs_sync  <= 3'b111;
		end else begin
			sck_sync <= {sck_sync[1:0], spi_sck};
			cs_sync  <= {cs_sync[1:0], spi_cs_n};
		end
	end

	// mosi kept aligned with sck_sync[1]
	always_ff @(posedge clk_sample) begin
		mosi_sync <= {mosi_sync[0], spi_mosi};
	end

	assign sck_rise  = sck_sync[1] & ~sck_sync[2];
	assign sck_fall  = ~sck_sync[1] & sck_sync[2];
	assign cs_rise   = cs_sync[1] & ~cs_sync[2];
	assign cs_active = ~cs_sync[1];
	assign shift_en  = sck_rise & cs_active;
	assign shift_nxt = {shift_in, mosi_sync[1]};

	// --------------------------------------------------
	// frame shifter and bit counter
	// --------------------------------------------------
	// counter saturates at a full frame, cs rise aborts
	always_ff @(posedge clk_sample) begin
		if (rst || cs_rise) begin
			bit_cnt <= '0;
		end else if (shift_en && bit_cnt != CNT_FULL) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sample) begin
		if (shift_en) begin
			shift_in <= shift_nxt[WORD_WD-2:0];
		end
	end

	// --------------------------------------------------
	// command decode
	// --------------------------------------------------
	always_ff @(posedge clk_sample) begin
		if (rst) begin
			cmd     <= 8'h00;
			rd_en   <= 1'b0;
			wr_en   <= 1'b0;
			rd_en_d <= 1'b0;
		end else begin
			// write strobe lasts one cycle
			wr_en   <= 1'b0;
			rd_en_d <= rd_en;
			if (cs_rise) begin
				rd_en <= 1'b0;
			end else if (shift_en) begin
				if (bit_cnt == CNT_CMD_END) begin
					cmd <= shift_nxt[7:0];
				end
				// read level raised once the address is in
				if (bit_cnt == CNT_ADDR_END) begin
					rd_en <= (cmd == SPI_CMD_RD);
				end
				if (bit_cnt == CNT_DATA_END) begin
					wr_en <= (cmd == SPI_CMD_WR);
				end
			end
		end
	end

	// address and data words, no reset
	always_ff @(posedge clk_sample) begin
		if (shift_en && bit_cnt == CNT_ADDR_END) begin
			addr <= shift_nxt[SPI_ADDR_LENGTH-1:0];
		end
		if (shift_en && bit_cnt == CNT_DATA_END) begin
			wr_data <= shift_nxt[SHORT_REG_WD-1:0];
		end
	end

	// --------------------------------------------------
	// read data select and miso shifter
	// --------------------------------------------------
	// zero when no list claims the address
	assign rd_sel_data = fix_sel ? fix_rd_data :
		ctrl_sel ? ctrl_rd_data : '0;
	assign rd_load = rd_en & ~rd_en_d;

	always_ff @(posedge clk_sample) begin
		if (rst || cs_rise) begin
			miso_sh <= '0;
		end else if (rd_load) begin
			miso_sh <= rd_sel_data;
		end else if (sck_fall && cs_active && bit_cnt > CNT_MISO_HOLD) begin
			miso_sh <= {miso_sh[SHORT_REG_WD-2:0], 1'b0};
		end
	end

	// msb first
	assign spi_miso = miso_sh[SHORT_REG_WD-1];

	// read level and write strobe belong to different frames
	a_rd_wr_excl: assert property (@(posedge clk_sample) disable iff (rst)
		!(rd_en && wr_en));

	// address maps of the two lists must not overlap
	a_sel_excl: assert property (@(posedge clk_sample) disable iff (rst)
		!(fix_sel && ctrl_sel));

endmodule

`default_nettype wire

/* hw/spi_reg_top.sv */
// spi register bank top: sampler with fixed and control register lists
`default_nettype none

module spi_reg_top #(
	parameter int SPI_ADDR_LENGTH = 16,
	parameter int SHORT_REG_WD    = 16
) (
	input  wire logic  clk_sample,
	input  wire logic  rst,
	// spi pins
	input  wire logic  spi_sck,
	input  wire logic  spi_cs_n,
	input  wire logic  spi_mosi,
	output logic       spi_miso,
	// camera control
	output logic       stream_en,
	output logic [15:0] exposure,
	output logic [7:0] gain,
	output logic [1:0] test_pattern
);

	// --------------------------------------------------
	// sampler to register lists
	// --------------------------------------------------
	logic                       rd_en;
	logic                       wr_en;
	logic [SPI_ADDR_LENGTH-1:0] addr;
	logic [SHORT_REG_WD-1:0]    wr_data;
	logic                       fix_sel;
	logic [SHORT_REG_WD-1:0]    fix_rd_data;
	logic                       ctrl_sel;
	logic [SHORT_REG_WD-1:0]    ctrl_rd_data;

	// spi front end
	spi_sampler #(
		.SPI_ADDR_LENGTH (SPI_ADDR_LENGTH),
		.SHORT_REG_WD    (SHORT_REG_WD)
	) spi_sampler_i (
		.clk_sample   (clk_sample),
		.rst          (rst),
		.spi_sck      (spi_sck),
		.spi_cs_n     (spi_cs_n),
		.spi_mosi     (spi_mosi),
		.spi_miso     (spi_miso),
		.rd_en        (rd_en),
		.wr_en        (wr_en),
		.addr         (addr),
		.wr_data      (wr_data),
		.fix_sel      (fix_sel),
		.fix_rd_data  (fix_rd_data),
		.ctrl_sel     (ctrl_sel),
		.ctrl_rd_data (ctrl_rd_data)
	);

	// version words, read only
	fix_reg_list #(
		.SPI_ADDR_LENGTH (SPI_ADDR_LENGTH),
		.SHORT_REG_WD    (SHORT_REG_WD)
	) fix_reg_list_i (
		.rd_en       (rd_en),
		.addr        (addr),
		.fix_sel     (fix_sel),
		.fix_rd_data (fix_rd_data)
	);

	// camera control registers
	ctrl_reg_list #(
		.SPI_ADDR_LENGTH (SPI_ADDR_LENGTH),
		.SHORT_REG_WD    (SHORT_REG_WD)
	) ctrl_reg_list_i (
		.clk_sample   (clk_sample),
		.rst          (rst),
		.rd_en        (rd_en),
		.wr_en        (wr_en),
		.addr         (addr),
		.wr_data      (wr_data),
		.ctrl_sel     (ctrl_sel),
		.ctrl_rd_data (ctrl_rd_data),
		.stream_en    (stream_en),
		.exposure     (exposure),
		.gain         (gain),
		.test_pattern (test_pattern)
	);

endmodule

`default_nettype wire

/* tests/tb_spi_reg_top.sv */
// testbench for the spi register bank: random spi frames checked against a register model
`default_nettype none

module tb_spi_reg_top;
	timeunit 1ns;
	timeprecision 100ps;
	import spi_reg_pkg::*;

	logic        clk_sample;
	logic        rst;
	logic        spi_sck;
	logic        spi_cs_n;
	logic        spi_mosi;
	logic        spi_miso;
	logic        stream_en;
	logic [15:0] exposure;
	logic [7:0]  gain;
	logic [1:0]  test_pattern;

	// expected control fields, already masked to their width
	logic [15:0] model [4];
	int          n_checks;
	int          n_errors;
	int          n_timeouts;

	spi_reg_top #(
		.SPI_ADDR_LENGTH (16),
		.SHORT_REG_WD    (16)
	) spi_reg_top_i (
		.clk_sample   (clk_sample),
		.rst          (rst),
		.spi_sck      (spi_sck),
		.spi_cs_n     (spi_cs_n),
		.spi_mosi     (spi_mosi),
		.spi_miso     (spi_miso),
		.stream_en    (stream_en),
		.exposure     (exposure),
		.gain         (gain),
		.test_pattern (test_pattern)
	);

	initial clk_sample = 1'b0;
	always #2 clk_sample = ~clk_sample;

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic idle_clks(input int n);
		repeat (n) @(posedge clk_sample);
	endtask

	task automatic check(input string name, input logic [15:0] exp_val,
		input logic [15:0] act_val);
		n_checks++;
		if (act_val !== exp_val) begin
			n_errors++;
			$display("error %s expected %h actual %h", name, exp_val, act_val);
		end
	endtask

	// width of each control field
	function automatic logic [15:0] field_mask(input logic [1:0] idx);
		case (idx)
			2'd0: return 16'h0001;
			2'd1: return 16'hffff;
			2'd2: return 16'h00ff;
			default: return 16'h0003;
		endcase
	endfunction

	// only the low 9 address bits select a register
	function automatic logic [15:0] expect_read(input logic [15:0] addr);
		case (addr[8:0])
			ADDR_VENDOR_ID: return VENDOR_ID;
			ADDR_PRODUCT_ID: return PRODUCT_ID;
			ADDR_FPGA_VER_H: return FPGA_VERSION_H;
			ADDR_FPGA_VER_L: return FPGA_VERSION_L;
			ADDR_TEST_VER: return TEST_VERSION;
			ADDR_STREAM_EN, ADDR_EXPOSURE, ADDR_GAIN, ADDR_TEST_PATTERN: return model[addr[1:0]];
			default: return 16'h0000;
		endcase
	endfunction

	function automatic void write_model(input logic [15:0] addr, input logic [15:0] data);
		if (addr[8:0] >= ADDR_STREAM_EN && addr[8:0] <= ADDR_TEST_PATTERN) begin
			model[addr[1:0]] = data & field_mask(addr[1:0]);
		end
	endfunction

	// control regs, version regs, aliases with high bits set, anything
	function automatic logic [15:0] pick_addr();
		int r;
		r = int'($urandom % 16);
		if (r < 8) begin
			return 16'h0020 + 16'($urandom % 4);
		end else if (r < 11) begin
			return 16'($urandom % 5);
		end else if (r < 13) begin
			return {7'($urandom), 9'h020 + 9'($urandom % 4)};
		end
		return 16'($urandom);
	endfunction

	function automatic logic outputs_match();
		return stream_en == model[0][0] && exposure == model[1] &&
			gain == model[2][7:0] && test_pattern == model[3][1:0];
	endfunction

	task automatic check_outputs(input string name);
		@(negedge clk_sample);
		check({name, " stream_en"}, model[0], 16'(stream_en));
		check({name, " exposure"}, model[1], exposure);
		check({name, " gain"}, model[2], 16'(gain));
		check({name, " test_pattern"}, model[3], 16'(test_pattern));
	endtask

	task automatic wait_outputs(input int limit);
		int n;
		n = 0;
		@(negedge clk_sample);
		while (!outputs_match() && n < limit) begin
			@(negedge clk_sample);
			n++;
		end
		if (!outputs_match()) begin
			n_timeouts++;
			$display("timeout: control outputs never took the written value");
		end
	endtask

	task automatic wait_reset_release(input int limit);
		int n;
		n = 0;
		while (rst && n < limit) begin
			@(posedge clk_sample);
			n++;
		end
		if (rst) begin
			n_timeouts++;
			$display("timeout: reset was never released");
		end
	endtask

	// --------------------------------------------------
	// spi mode 0 frame, sck at clk/8
	// --------------------------------------------------
	// nbits below 40 aborts the frame early
	task automatic spi_frame(input logic [7:0] cmd, input logic [15:0] addr,
		input logic [15:0] data, input int nbits, output logic [15:0] rd_word);
		logic [39:0] word;
		word = {cmd, addr, data};
		rd_word = 16'h0000;
		@(posedge clk_sample);
		spi_cs_n <= 1'b0;
		spi_sck  <= 1'b0;
		for (int i = 0; i < nbits; i++) begin
			// mosi moves while sck is low
			spi_mosi <= word[39 - i];
			idle_clks(3);
			// miso is settled half a clock before the rise
			@(negedge clk_sample);
			if (i >= 24) begin
				rd_word = {rd_word[14:0], spi_miso};
			end
			@(posedge clk_sample);
			spi_sck <= 1'b1;
			idle_clks(4);
			spi_sck <= 1'b0;
		end
		idle_clks(4);
		spi_cs_n <= 1'b1;
		spi_mosi <= 1'b0;
		// gap lets the sampler see the cs rise
		idle_clks(8);
	endtask

	initial begin : reset_drive
		rst      = 1'b1;
		spi_sck  = 1'b0;
		spi_cs_n = 1'b1;
		spi_mosi = 1'b0;
		repeat (16) @(posedge clk_sample);
		rst <= 1'b0;
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin : main
		int unsigned seed_val;
		logic [15:0] rd;
		logic [15:0] addr;
		logic [15:0] data;
		logic [7:0]  cmd;
		int          nbits;
		seed_val = $urandom(32'h95a7_44c9);
		n_checks = 0;
		n_errors = 0;
		n_timeouts = 0;
		// power-up control values
		model[0] = 16'h0000;
		model[1] = 16'h0400;
		model[2] = 16'h0010;
		model[3] = 16'h0000;
		wait_reset_release(100);
		idle_clks(4);

		// reset values on the ports and over spi
		check_outputs("reset outputs");
		for (int k = 0; k < 4; k++) begin
			addr = 16'(ADDR_STREAM_EN) + 16'(k);
			spi_frame(SPI_CMD_RD, addr, 16'h0000, 40, rd);
			check("reset read", expect_read(addr), rd);
		end
		// version words
		for (int k = 0; k < 5; k++) begin
			addr = 16'(k);
			spi_frame(SPI_CMD_RD, addr, 16'h0000, 40, rd);
			check("version read", expect_read(addr), rd);
		end
		for (int k = 0; k < 300; k++) begin
			addr = pick_addr();
			data = 16'($urandom);
			spi_frame(SPI_CMD_WR, addr, data, 40, rd);
			write_model(addr, data);
			wait_outputs(32);
			check_outputs("random write");
		end
		for (int k = 0; k < 300; k++) begin
			addr = pick_addr();
			spi_frame(SPI_CMD_RD, addr, 16'($urandom), 40, rd);
			check("random read", expect_read(addr), rd);
		end
		// cs rises before the write strobe
		for (int k = 0; k < 50; k++) begin
			nbits = 1 + int'($urandom % 39);
			addr = 16'h0020 + 16'($urandom % 4);
			spi_frame(SPI_CMD_WR, addr, 16'($urandom), nbits, rd);
			check_outputs("aborted write");
		end
		for (int k = 0; k < 50; k++) begin
			cmd = 8'($urandom);
			// bump a real command to a neighbouring unused code
			if (cmd == SPI_CMD_RD || cmd == SPI_CMD_WR) begin
				cmd = cmd ^ 8'h01;
			end
			spi_frame(cmd, pick_addr(), 16'($urandom), 40, rd);
			check_outputs("unknown command");
			addr = pick_addr();
			spi_frame(SPI_CMD_RD, addr, 16'h0000, 40, rd);
			check("read after unknown command", expect_read(addr), rd);
		end

		$display("checks %0d errors %0d timeouts %0d", n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* spi_reg_top.f */
hw/spi_reg_pkg.sv
hw/fix_reg_list.sv
hw/ctrl_reg_list.sv
hw/spi_sampler.sv
hw/spi_reg_top.sv
tests/tb_spi_reg_top.sv

/* Makefile */
LOG := sim.log

.PHONY: simulate clean

simulate:
	rm -f $(LOG)
	verilator --binary --assert -sv --top-module tb_spi_reg_top -f spi_reg_top.f -o vsim
	./obj_dir/vsim | tee $(LOG)
	grep -F -q "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
